//--- hw/dispatch_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes and index widths for the rename and dispatch stage
// include wherever a size or width is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

// register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 40

// instruction window
`define ROB_DEPTH 16

// index widths, kept in step with the sizes above
`define AREG_W    5
`define PREG_W    6
`define ROB_IDX_W 4

`endif

//--- hw/dispatch_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the rename and dispatch stage
// register indices, the instruction word views and the stage packets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "dispatch_params.svh"

package dispatch_pkg;

    typedef logic [`AREG_W-1:0]    areg_t;
    typedef logic [`PREG_W-1:0]    preg_t;
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    // R-type layout, rd is meaningful here
    typedef struct packed {
        logic [6:0] funct7;
        areg_t      rs2;
        areg_t      rs1;
        logic [2:0] funct3;
        areg_t      rd;
        logic [6:0] opcode;
    } r_fields_t;

    // S/B-type layout, rd bits become imm_lo
    typedef struct packed {
        logic [6:0] imm_hi;
        areg_t      rs2;
        areg_t      rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fields_t;

    typedef union packed {
        r_fields_t r_view;
        s_fields_t s_view;
    } inst_word_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        inst_word_t  inst;
    } fetch_packet_t;

    typedef struct packed {
        logic has_dest;
        logic has_rs1;
        logic has_rs2;
        logic illegal;
    } decode_info_t;

    typedef struct packed {
        logic [31:0] pc;
        areg_t       arch_dest;
        preg_t       dest;
        preg_t       old_dest;
        logic        has_dest;
    } rob_entry_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        inst_word_t  inst;
        preg_t       src1;
        preg_t       src2;
        preg_t       dest;
        preg_t       old_dest;
        areg_t       arch_dest;
        logic        has_dest;
        rob_idx_t    rob_idx;
    } rename_packet_t;

endpackage

`default_nettype wire

//--- hw/inst_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I opcode classifier for register use
// purely combinational, feeds the dispatch control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
    input  dispatch_pkg::inst_word_t   inst,
    output dispatch_pkg::decode_info_t info
);
    import dispatch_pkg::*;

    // base opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    always_comb begin
        info = '0;
        case (inst.r_view.opcode)
            OPC_OP:                info = '{has_dest: 1'b1, has_rs1: 1'b1,
                                            has_rs2: 1'b1, illegal: 1'b0};
            OPC_OP_IMM, OPC_LOAD,
            OPC_JALR:              info = '{has_dest: 1'b1, has_rs1: 1'b1,
                                            has_rs2: 1'b0, illegal: 1'b0};
            // S and B formats, no rd field at all
            OPC_STORE, OPC_BRANCH: info = '{has_dest: 1'b0, has_rs1: 1'b1,
                                            has_rs2: 1'b1, illegal: 1'b0};
            // upper immediates and jal only write
            OPC_LUI, OPC_AUIPC,
            OPC_JAL:               info = '{has_dest: 1'b1, has_rs1: 1'b0,
                                            has_rs2: 1'b0, illegal: 1'b0};
            default:               info.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/map_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// speculative and architectural register maps
// lookups are combinational, rename/commit/restore happen on the edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "dispatch_params.svh"

module map_table (
    input  logic                clock,
    input  logic                reset,
    input  dispatch_pkg::areg_t src1_arch,
    input  dispatch_pkg::areg_t src2_arch,
    output dispatch_pkg::preg_t src1_preg,
    output dispatch_pkg::preg_t src2_preg,
    input  dispatch_pkg::areg_t dest_arch,
    input  logic                set_dest,
    input  dispatch_pkg::preg_t new_dest,
    output dispatch_pkg::preg_t old_dest,
    input  logic                retire_en,
    input  dispatch_pkg::areg_t retire_arch,
    input  dispatch_pkg::preg_t retire_preg,
    input  logic                restore
);
    import dispatch_pkg::*;

    preg_t spec_map [`ARCH_REGS];
    preg_t arch_map [`ARCH_REGS];
    // arch map including this cycle's commit
    preg_t arch_next [`ARCH_REGS];

    assign src1_preg = spec_map[src1_arch];
    assign src2_preg = spec_map[src2_arch];
    assign old_dest  = spec_map[dest_arch];

    always_comb begin
        arch_next = arch_map;
        if (retire_en) begin
            arch_next[retire_arch] = retire_preg;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity mapping out of reset
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i] <= preg_t'(i);
                arch_map[i] <= preg_t'(i);
            end
        end else begin
            arch_map <= arch_next;
            // restore sees a retire in the same edge
            if (restore) begin
                spec_map <= arch_next;
            end else if (set_dest) begin
                spec_map[dest_arch] <= new_dest;
            end
        end
    end

    // x0 stays pinned to preg 0
    assert property (@(posedge clock) disable iff (reset) set_dest |-> dest_arch != '0);

endmodule

`default_nettype wire

//--- hw/free_list.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular queue of free physical registers
// a committed head tracks retirement so rollback can rewind allocations
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "dispatch_params.svh"

module free_list (
    input  logic                clock,
    input  logic                reset,
    input  logic                pop,
    output dispatch_pkg::preg_t free_preg,
    output logic                empty,
    input  logic                push,
    input  dispatch_pkg::preg_t push_preg,
    input  logic                commit,
    input  logic                rewind
);
    import dispatch_pkg::*;

    localparam int FL_SIZE = `PHYS_REGS - `ARCH_REGS;
    localparam int PTR_W   = $clog2(FL_SIZE);
    localparam int CNT_W   = $clog2(FL_SIZE + 1);

    preg_t             slots [FL_SIZE];
    logic [PTR_W-1:0]  head;
    logic [PTR_W-1:0]  tail;
    logic [PTR_W-1:0]  commit_head;
    logic [PTR_W-1:0]  commit_next;
    logic [CNT_W-1:0]  count;

    function automatic logic [PTR_W-1:0] step(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FL_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign free_preg   = slots[head];
    // empty from the count before any push this cycle
    assign empty       = (count == '0);
    assign commit_next = commit ? step(commit_head) : commit_head;

    always_ff @(posedge clock) begin
        if (reset) begin
            // pregs above the arch range start out free
            for (int i = 0; i < FL_SIZE; i++) begin
                slots[i] <= preg_t'(`ARCH_REGS + i);
            end
            head        <= '0;
            tail        <= '0;
            commit_head <= '0;
            count       <= CNT_W'(FL_SIZE);
        end else begin
            if (push) begin
                slots[tail] <= push_preg;
                tail        <= step(tail);
            end
            commit_head <= commit_next;
            if (rewind) begin
                // committed state always holds every spare preg
                head  <= commit_next;
                count <= CNT_W'(FL_SIZE);
            end else begin
                if (pop)
                    head <= step(head);
                count <= count + CNT_W'(push) - CNT_W'(pop);
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset) pop |-> !empty);

endmodule

`default_nettype wire

//--- hw/reorder_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in-order instruction window
// alloc at the tail, retire from the head, flush drops everything
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "dispatch_params.svh"

module reorder_buffer (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     alloc,
    input  dispatch_pkg::rob_entry_t alloc_entry,
    output dispatch_pkg::rob_idx_t   alloc_idx,
    output logic                     full,
    input  logic                     retire,
    output dispatch_pkg::rob_entry_t head_entry,
    output logic                     head_valid,
    input  logic                     flush
);
    import dispatch_pkg::*;

    rob_entry_t             entries [`ROB_DEPTH];
    rob_idx_t               head;
    rob_idx_t               tail;
    // one extra bit so a full window is distinct from empty
    logic [`ROB_IDX_W:0]    count;

    assign alloc_idx  = tail;
    assign head_entry = entries[head];
    assign head_valid = (count != '0);
    assign full       = (count == (`ROB_IDX_W+1)'(`ROB_DEPTH));

    // entry payload, written at the tail slot
    always_ff @(posedge clock) begin
        if (alloc) begin
            entries[tail] <= alloc_entry;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // depth is a power of two, pointers wrap on their own
            if (alloc) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + (`ROB_IDX_W+1)'(alloc) - (`ROB_IDX_W+1)'(retire);
        end
    end

    assert property (@(posedge clock) disable iff (reset) alloc |-> !full);

    // caller may only retire a live head
    assert property (@(posedge clock) disable iff (reset) retire |-> head_valid);

endmodule

`default_nettype wire

//--- hw/dispatch_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// accept/stall decision, allocation strobes and the rename register
// rename output is valid one cycle after the accepting edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dispatch_control (
    input  logic                         clock,
    input  logic                         reset,
    input  dispatch_pkg::fetch_packet_t  fetch,
    input  dispatch_pkg::decode_info_t   info,
    input  logic                         rob_full,
    input  logic                         fl_empty,
    input  logic                         rollback,
    input  dispatch_pkg::preg_t          src1,
    input  dispatch_pkg::preg_t          src2,
    input  dispatch_pkg::preg_t          old_dest,
    input  dispatch_pkg::preg_t          free_preg,
    input  dispatch_pkg::rob_idx_t       alloc_idx,
    output logic                         stall,
    output logic                         alloc,
    output logic                         pop,
    output logic                         set_dest,
    output dispatch_pkg::preg_t          dest,
    output dispatch_pkg::rename_packet_t rename
);
    import dispatch_pkg::*;

    logic           legal;
    logic           needs_dest;
    rename_packet_t next_pkt;
    rename_packet_t pkt_q;

    // state only, independent of the presented packet
    assign stall      = rob_full | fl_empty;
    // illegal packets are consumed with no allocation
    assign legal      = fetch.valid & ~stall & ~rollback & ~info.illegal;
    // x0 writes never get a fresh preg
    assign needs_dest = info.has_dest & (fetch.inst.r_view.rd != '0);

    assign alloc    = legal;
    assign pop      = legal & needs_dest;
    assign set_dest = pop;
    assign dest     = pop ? free_preg : '0;

    always_comb begin
        next_pkt           = '0;
        next_pkt.valid     = legal;
        next_pkt.pc        = fetch.pc;
        next_pkt.inst      = fetch.inst;
        // unused sources read x0, which is always preg 0
        next_pkt.src1      = info.has_rs1 ? src1 : '0;
        next_pkt.src2      = info.has_rs2 ? src2 : '0;
        next_pkt.dest      = dest;
        next_pkt.old_dest  = needs_dest ? old_dest : '0;
        next_pkt.arch_dest = needs_dest ? fetch.inst.r_view.rd : '0;
        next_pkt.has_dest  = needs_dest;
        next_pkt.rob_idx   = alloc_idx;
    end

    // rename register, one cycle behind the accepting edge
    always_ff @(posedge clock) begin
        if (reset) begin
            pkt_q.valid <= 1'b0;
        end else begin
            pkt_q <= next_pkt;
        end
    end

    assign rename = pkt_q;

endmodule

`default_nettype wire

//--- hw/dispatch_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rename and dispatch stage top
// fetch packets in, rename packets out, retire and rollback from outside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dispatch_stage (
    input  logic                         clock,
    input  logic                         reset,
    input  dispatch_pkg::fetch_packet_t  fetch,
    output logic                         stall,
    output dispatch_pkg::rename_packet_t rename,
    input  logic                         retire,
    output dispatch_pkg::rob_entry_t     head_entry,
    output logic                         head_valid,
    input  logic                         rollback
);
    import dispatch_pkg::*;

    decode_info_t info;
    preg_t        src1, src2, old_dest, free_preg, dest;
    rob_idx_t     alloc_idx;
    logic         rob_full, fl_empty, alloc, pop, set_dest;
    logic         retire_dest;

    // only entries that took a preg commit and recycle one
    assign retire_dest = retire & head_entry.has_dest;

    inst_decoder i_decoder (.inst(fetch.inst), .info(info));

    map_table i_map_table (
        .clock(clock), .reset(reset),
        .src1_arch(fetch.inst.r_view.rs1), .src2_arch(fetch.inst.r_view.rs2),
        .src1_preg(src1), .src2_preg(src2),
        .dest_arch(fetch.inst.r_view.rd), .set_dest(set_dest), .new_dest(dest),
        .old_dest(old_dest),
        .retire_en(retire_dest), .retire_arch(head_entry.arch_dest),
        .retire_preg(head_entry.dest), .restore(rollback)
    );

    free_list i_free_list (
        .clock(clock), .reset(reset), .pop(pop), .free_preg(free_preg), .empty(fl_empty),
        .push(retire_dest), .push_preg(head_entry.old_dest),
        .commit(retire_dest), .rewind(rollback)
    );

    reorder_buffer i_rob (
        .clock(clock), .reset(reset), .alloc(alloc),
        .alloc_entry('{pc: fetch.pc, arch_dest: rename_arch_dest(fetch, info), dest: dest,
                       old_dest: set_dest ? old_dest : '0, has_dest: set_dest}),
        .alloc_idx(alloc_idx), .full(rob_full), .retire(retire),
        .head_entry(head_entry), .head_valid(head_valid), .flush(rollback)
    );

    dispatch_control i_control (
        .clock(clock), .reset(reset), .fetch(fetch), .info(info),
        .rob_full(rob_full), .fl_empty(fl_empty), .rollback(rollback),
        .src1(src1), .src2(src2), .old_dest(old_dest), .free_preg(free_preg),
        .alloc_idx(alloc_idx), .stall(stall), .alloc(alloc), .pop(pop),
        .set_dest(set_dest), .dest(dest), .rename(rename)
    );

    // arch dest is only recorded when a preg is taken
    function automatic areg_t rename_arch_dest(input fetch_packet_t pkt,
                                               input decode_info_t  dec);
        return (dec.has_dest && pkt.inst.r_view.rd != '0) ? pkt.inst.r_view.rd : '0;
    endfunction

endmodule

`default_nettype wire

//--- verification/dispatch_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the rename and dispatch stage
// directed tests then random traffic, checked against a rename model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "dispatch_params.svh"

module dispatch_tb;
    import dispatch_pkg::*;

    // directed part stays under 100 cycles, random part is 150
    localparam int MAX_CYCLES = 400;
    localparam int FL_SIZE    = `PHYS_REGS - `ARCH_REGS;

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_BAD   = 7'b1111111;
    // nine legal opcodes plus one illegal
    localparam logic [6:0] OPCODES [10] = '{7'b0110011, 7'b0010011, 7'b0000011,
        7'b0100011, 7'b1100011, 7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111,
        7'b1111111};

    logic           clock, reset, retire, rollback, stall, head_valid;
    fetch_packet_t  fetch;
    rename_packet_t rename;
    rob_entry_t     head_entry;

    // reference model state
    preg_t          spec_m [`ARCH_REGS];
    preg_t          arch_m [`ARCH_REGS];
    preg_t          free_q [FL_SIZE];
    int             fl_head, fl_tail, fl_commit, fl_count;
    rob_entry_t     rob_m [`ROB_DEPTH];
    int             rob_head, rob_tail, rob_count;
    rename_packet_t pending;

    integer         seed;
    string          test_name;
    int             cycle_count = 0;
    logic [31:0]    pc_next;

    dispatch_stage i_dut (
        .clock(clock), .reset(reset), .fetch(fetch), .stall(stall), .rename(rename),
        .retire(retire), .head_entry(head_entry), .head_valid(head_valid),
        .rollback(rollback)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) cycle_count <= cycle_count + 1;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    initial begin
        wait (cycle_count >= MAX_CYCLES);
        fail_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end

    task automatic check_rename(input rename_packet_t exp, input rename_packet_t act);
        // payload only matters on a valid packet
        if (act.valid !== exp.valid || (exp.valid && act !== exp))
            fail_run($sformatf("FAIL %s rename: expected %h actual %h", test_name, exp, act));
    endtask

    task automatic check_head(input rob_entry_t exp, input rob_entry_t act);
        if (act !== exp)
            fail_run($sformatf("FAIL %s head_entry: expected %h actual %h",
                               test_name, exp, act));
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("FAIL %s %s: expected %b actual %b", test_name, what, exp, act));
    endtask

    // register use straight from the RV32I opcode map
    // order is has_dest, has_rs1, has_rs2, illegal
    function automatic decode_info_t ref_decode(input logic [6:0] opc);
        case (opc)
            7'b0110011:                         return 4'b1110;
            7'b0010011, 7'b0000011, 7'b1100111: return 4'b1100;
            7'b0100011, 7'b1100011:             return 4'b0110;
            7'b0110111, 7'b0010111, 7'b1101111: return 4'b1000;
            default:                            return 4'b0001;
        endcase
    endfunction

    task automatic model_reset();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            spec_m[i] = preg_t'(i);
            arch_m[i] = preg_t'(i);
        end
        for (int i = 0; i < FL_SIZE; i++)
            free_q[i] = preg_t'(`ARCH_REGS + i);
        fl_head   = 0;
        fl_tail   = 0;
        fl_commit = 0;
        fl_count  = FL_SIZE;
        rob_head  = 0;
        rob_tail  = 0;
        rob_count = 0;
    endtask

    function automatic logic model_busy();
        return (rob_count == `ROB_DEPTH) || (fl_count == 0);
    endfunction

    // expected rename packet for the presented fetch, from pre-edge model state
    function automatic rename_packet_t model_rename(input fetch_packet_t f, input logic rb);
        rename_packet_t p;
        decode_info_t   d;
        logic           need;
        d    = ref_decode(f.inst.r_view.opcode);
        need = d.has_dest && (f.inst.r_view.rd != '0);
        p           = '0;
        p.valid     = f.valid && !model_busy() && !rb && !d.illegal;
        p.pc        = f.pc;
        p.inst      = f.inst;
        p.src1      = d.has_rs1 ? spec_m[f.inst.r_view.rs1] : '0;
        p.src2      = d.has_rs2 ? spec_m[f.inst.r_view.rs2] : '0;
        p.dest      = need ? free_q[fl_head] : '0;
        p.old_dest  = need ? spec_m[f.inst.r_view.rd] : '0;
        p.arch_dest = need ? f.inst.r_view.rd : '0;
        p.has_dest  = need;
        p.rob_idx   = rob_idx_t'(rob_tail);
        return p;
    endfunction

    // one clock edge of the model
    task automatic model_advance(input rename_packet_t p, input logic ret, input logic rb);
        rob_entry_t e;
        if (ret) begin
            e = rob_m[rob_head];
            if (e.has_dest) begin
                arch_m[e.arch_dest] = e.dest;
                free_q[fl_tail]     = e.old_dest;
                fl_tail   = (fl_tail + 1) % FL_SIZE;
                fl_commit = (fl_commit + 1) % FL_SIZE;
                fl_count  = fl_count + 1;
            end
            rob_head  = (rob_head + 1) % `ROB_DEPTH;
            rob_count = rob_count - 1;
        end
        if (rb) begin
            // committed state, every spare preg free again
            spec_m    = arch_m;
            fl_head   = fl_commit;
            fl_count  = FL_SIZE;
            rob_head  = 0;
            rob_tail  = 0;
            rob_count = 0;
        end else if (p.valid) begin
            e.pc        = p.pc;
            e.arch_dest = p.arch_dest;
            e.dest      = p.dest;
            e.old_dest  = p.old_dest;
            e.has_dest  = p.has_dest;
            rob_m[rob_tail] = e;
            rob_tail  = (rob_tail + 1) % `ROB_DEPTH;
            rob_count = rob_count + 1;
            if (p.has_dest) begin
                spec_m[p.arch_dest] = p.dest;
                fl_head  = (fl_head + 1) % FL_SIZE;
                fl_count = fl_count - 1;
            end
        end
    endtask

    // compare at the falling edge, inputs and outputs both settled there
    always @(negedge clock) begin
        if (reset) begin
            model_reset();
            pending = '0;
        end else begin
            check_bit("stall", model_busy(), stall);
            check_bit("head_valid", rob_count != 0, head_valid);
            if (rob_count != 0)
                check_head(rob_m[rob_head], head_entry);
            check_rename(pending, rename);
            pending = model_rename(fetch, rollback);
            model_advance(pending, retire, rollback);
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // store callers pass imm_lo in the rd slot
    function automatic inst_word_t encode(input logic [6:0] opc, input areg_t rd,
                                          input areg_t rs1, input areg_t rs2);
        inst_word_t w;
        w = '0;
        w.r_view.opcode = opc;
        w.r_view.rd     = rd;
        w.r_view.rs1    = rs1;
        w.r_view.rs2    = rs2;
        return w;
    endfunction

    // holds the packet until an edge without stall or rollback takes it
    task automatic send_inst(input inst_word_t w);
        logic taken;
        fetch.valid = 1'b1;
        fetch.pc    = pc_next;
        fetch.inst  = w;
        taken = !stall && !rollback;
        next_cycle();
        while (!taken) begin
            taken = !stall && !rollback;
            next_cycle();
        end
        fetch.valid = 1'b0;
        pc_next = pc_next + 4;
    endtask

    task automatic retire_one();
        while (!head_valid)
            next_cycle();
        retire = 1'b1;
        next_cycle();
        retire = 1'b0;
    endtask

    task automatic retire_all();
        while (head_valid)
            retire_one();
    endtask

    task automatic do_rollback();
        rollback = 1'b1;
        next_cycle();
        rollback = 1'b0;
    endtask

    task automatic random_inst(output inst_word_t w);
        int pick;
        w    = $random(seed);
        pick = {$random(seed)} % 10;
        w.r_view.opcode = OPCODES[pick];
    endtask

    initial begin : stimulus
        logic       taken;
        inst_word_t w;
        reset     = 1'b1;
        fetch     = '0;
        retire    = 1'b0;
        rollback  = 1'b0;
        seed      = 15;
        pc_next   = 32'h0000_1000;
        test_name = "reset";
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        // x6 reads x5 which was just renamed
        test_name = "rename_chain";
        send_inst(encode(OPC_OP, 5'd5, 5'd1, 5'd2));
        send_inst(encode(OPC_OP, 5'd6, 5'd5, 5'd3));

        // no dest, rd zero, illegal, then a fresh dest
        test_name = "dest_order";
        send_inst(encode(OPC_STORE, 5'd9, 5'd4, 5'd6));
        send_inst(encode(OPC_OP, 5'd0, 5'd5, 5'd6));
        send_inst(encode(OPC_BAD, 5'd7, 5'd1, 5'd1));
        send_inst(encode(OPC_LUI, 5'd7, 5'd0, 5'd0));
        do_rollback();

        // drain all eight spare pregs
        test_name = "stall_free_list";
        for (int i = 1; i <= FL_SIZE; i++)
            send_inst(encode(OPC_LUI, areg_t'(i), 5'd0, 5'd0));
        fetch = '{valid: 1'b1, pc: pc_next, inst: encode(OPC_LUI, 5'd9, 5'd0, 5'd0)};
        repeat (3) next_cycle();
        check_bit("stall_held", 1'b1, stall);
        retire_one();
        send_inst(encode(OPC_LUI, 5'd9, 5'd0, 5'd0));
        do_rollback();

        // stores only, so the ROB fills first
        test_name = "stall_rob_full";
        for (int i = 0; i < `ROB_DEPTH; i++)
            send_inst(encode(OPC_STORE, 5'd1, 5'd2, 5'd3));
        fetch = '{valid: 1'b1, pc: pc_next, inst: encode(OPC_STORE, 5'd2, 5'd4, 5'd5)};
        repeat (3) next_cycle();
        check_bit("stall_held", 1'b1, stall);
        retire_one();
        send_inst(encode(OPC_STORE, 5'd2, 5'd4, 5'd5));
        do_rollback();

        // recycled pregs come back at the tail
        test_name = "retire_order";
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 6; i++)
                send_inst(encode(OPC_LUI, areg_t'(20 + i), 5'd0, 5'd0));
            retire_all();
        end

        // only the retired x10 survives the rollback
        test_name = "rollback_restore";
        send_inst(encode(OPC_LUI, 5'd10, 5'd0, 5'd0));
        send_inst(encode(OPC_LUI, 5'd11, 5'd0, 5'd0));
        retire_one();
        do_rollback();
        send_inst(encode(OPC_OP, 5'd13, 5'd10, 5'd11));
        send_inst(encode(OPC_LUI, 5'd14, 5'd0, 5'd0));
        retire_all();

        test_name = "random_traffic";
        taken = 1'b0;
        for (int n = 0; n < 150; n++) begin
            // a stalled packet stays in place
            if (!fetch.valid || taken) begin
                random_inst(w);
                fetch.valid = ($random(seed) & 3) != 0;
                fetch.pc    = pc_next;
                fetch.inst  = w;
                pc_next     = pc_next + 4;
            end
            retire   = head_valid && (($random(seed) & 1) != 0);
            rollback = ($random(seed) & 31) == 0;
            taken    = fetch.valid && !stall && !rollback;
            next_cycle();
        end
        fetch    = '0;
        retire   = 1'b0;
        rollback = 1'b0;
        repeat (3) next_cycle();

        if (cycle_count < MAX_CYCLES) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_run("run ended past the cycle limit");
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/dispatch_pkg.sv
hw/inst_decoder.sv
hw/map_table.sv
hw/free_list.sv
hw/reorder_buffer.sv
hw/dispatch_control.sv
hw/dispatch_stage.sv
verification/dispatch_tb.sv

//--- Bender.yml
package:
  name: dispatch_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/dispatch_pkg.sv
      - hw/inst_decoder.sv
      - hw/map_table.sv
      - hw/free_list.sv
      - hw/reorder_buffer.sv
      - hw/dispatch_control.sv
      - hw/dispatch_stage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/dispatch_tb.sv
